// File: hdl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder #(
    parameter int UART_COUNT = 2
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  soc_bus_pkg::wb_req_t    i_req,
    output soc_bus_pkg::slave_sel_t o_slave_sel,
    output soc_bus_pkg::wb_rsp_t    o_default_rsp
);

    import soc_bus_pkg::*;

    // highest select index with a slave behind it.
    localparam int LAST_MAPPED = SLAVE_TCM + UART_COUNT;

    logic [SLAVE_SEL_WIDTH-1:0] slave_idx;
    logic                       unmapped;
    logic                       default_ack;

    assign slave_idx = i_req.adr[31 -: SLAVE_SEL_WIDTH];
    assign unmapped  = (int'(slave_idx) > LAST_MAPPED);

    // one-hot select, only inside a cycle.
    always_comb begin
        o_slave_sel = '0;
        if (i_req.cyc) begin
            o_slave_sel[slave_idx] = 1'b1;
        end
    end

    // unmapped accesses still get a single ack.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= i_req.cyc & i_req.stb & unmapped & ~default_ack;
        end
    end

    assign o_default_rsp.dat = '0;
    assign o_default_rsp.ack = default_ack;

endmodule

// File: hdl/bus_read_mux.sv
`timescale 1ns/1ps

module bus_read_mux (
    input  soc_bus_pkg::slave_sel_t                             i_slave_sel,
    input  soc_bus_pkg::wb_rsp_t [soc_bus_pkg::SLAVE_COUNT-1:0] i_slave_rsp,
    input  soc_bus_pkg::wb_rsp_t                                i_default_rsp,
    output soc_bus_pkg::wb_rsp_t                                o_rsp
);

    import soc_bus_pkg::*;

    // idle slaves drive zero, so a plain or is enough.
    always_comb begin
        o_rsp = i_default_rsp;
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (i_slave_sel[i]) begin
                o_rsp.dat = o_rsp.dat | i_slave_rsp[i].dat;
                o_rsp.ack = o_rsp.ack | i_slave_rsp[i].ack;
            end
        end
    end

endmodule

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // address map.
    localparam int SLAVE_SEL_WIDTH = 4;
    localparam int SLAVE_COUNT     = 2 ** SLAVE_SEL_WIDTH;
    localparam int SLAVE_TCM       = 0;

    typedef logic [31:0]              wb_addr_t;
    typedef logic [31:0]              wb_data_t;
    typedef logic [3:0]               wb_sel_t;
    typedef logic [SLAVE_COUNT-1:0]   slave_sel_t;
    typedef logic [7:0]               uart_byte_t;

    // master request, held until ack.
    typedef struct packed {
        wb_addr_t   adr;
        wb_data_t   dat;
        wb_sel_t    sel;
        logic       we;
        logic       stb;
        logic       cyc;
    } wb_req_t;

    // slave reply, dat is zero unless ack.
    typedef struct packed {
        wb_data_t   dat;
        logic       ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_t;

endpackage

// File: hdl/soc_periph_top.sv
`timescale 1ns/1ps

module soc_periph_top #(
    parameter int TCM_ADDR_WIDTH = 8,
    parameter int UART_COUNT     = 2,
    parameter int CLKS_PER_BIT   = 8
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  soc_bus_pkg::wb_req_t    i_req,
    output soc_bus_pkg::wb_rsp_t    o_rsp,
    input  logic [UART_COUNT-1:0]   i_rx,
    output logic [UART_COUNT-1:0]   o_tx
);

    import soc_bus_pkg::*;

    slave_sel_t                     slave_sel;
    wb_rsp_t [SLAVE_COUNT-1:0]      slave_rsp;
    wb_rsp_t                        default_rsp;

    bus_decoder #(
        .UART_COUNT         (UART_COUNT)
    ) u_decoder (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_req              (i_req),
        .o_slave_sel        (slave_sel),
        .o_default_rsp      (default_rsp)
    );

    tcm #(
        .TCM_ADDR_WIDTH     (TCM_ADDR_WIDTH)
    ) u_tcm (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_sel              (slave_sel[SLAVE_TCM]),
        .i_req              (i_req),
        .o_rsp              (slave_rsp[SLAVE_TCM])
    );

    // channel n sits at select index 1 + n.
    for (genvar n = 0; n < UART_COUNT; n++) begin : g_uart
        uart_channel #(
            .CLKS_PER_BIT   (CLKS_PER_BIT)
        ) u_uart (
            .i_clk          (i_clk),
            .i_rst          (i_rst),
            .i_sel          (slave_sel[SLAVE_TCM+1+n]),
            .i_req          (i_req),
            .o_rsp          (slave_rsp[SLAVE_TCM+1+n]),
            .i_rx           (i_rx[n]),
            .o_tx           (o_tx[n])
        );
    end

    // unused slots.
    for (genvar s = SLAVE_TCM + UART_COUNT + 1; s < SLAVE_COUNT; s++) begin : g_unused
        assign slave_rsp[s] = '0;
    end

    bus_read_mux u_read_mux (
        .i_slave_sel        (slave_sel),
        .i_slave_rsp        (slave_rsp),
        .i_default_rsp      (default_rsp),
        .o_rsp              (o_rsp)
    );

endmodule

// File: hdl/tcm.sv
`timescale 1ns/1ps

module tcm #(
    parameter int TCM_ADDR_WIDTH = 8
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_sel,
    input  soc_bus_pkg::wb_req_t    i_req,
    output soc_bus_pkg::wb_rsp_t    o_rsp
);

    import soc_bus_pkg::*;

    localparam int DEPTH = 2 ** TCM_ADDR_WIDTH;
    localparam int LANES = $bits(wb_sel_t);

    wb_data_t                   mem [DEPTH];
    logic [TCM_ADDR_WIDTH-1:0]  word_addr;
    logic                       hit;
    logic                       ack;
    wb_data_t                   rdata;

    assign word_addr = i_req.adr[TCM_ADDR_WIDTH+1:2];

    // a held request is served once.
    assign hit = i_sel & i_req.cyc & i_req.stb & ~ack;

    // byte lane writes.
    always_ff @(posedge i_clk) begin
        if (hit && i_req.we) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (i_req.sel[lane]) begin
                    mem[word_addr][8*lane +: 8] <= i_req.dat[8*lane +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            ack   <= hit;
            rdata <= (hit && !i_req.we) ? mem[word_addr] : '0;
        end
    end

    assign o_rsp.dat = rdata;
    assign o_rsp.ack = ack;

endmodule

// File: hdl/uart_channel.sv
`timescale 1ns/1ps

module uart_channel #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_sel,
    input  soc_bus_pkg::wb_req_t    i_req,
    output soc_bus_pkg::wb_rsp_t    o_rsp,
    input  logic                    i_rx,
    output logic                    o_tx
);

    import soc_bus_pkg::*;

    localparam int BAUD_W = $clog2(CLKS_PER_BIT + 1);
    localparam int MID    = (CLKS_PER_BIT / 2 > 0) ? CLKS_PER_BIT / 2 - 1 : 0;

    localparam logic [BAUD_W-1:0] BIT_LAST = BAUD_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_W-1:0] BIT_MID  = BAUD_W'(MID);

    localparam logic [1:0] REG_DATA   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;

    // bus side.
    logic [1:0]         reg_ofs;
    logic               bus_hit;
    logic               bus_ack;
    wb_data_t           bus_rdata;
    wb_data_t           reg_rdata;
    logic               tx_load;
    logic               data_rd;

    // transmitter.
    uart_tx_state_t     tx_state;
    logic [BAUD_W-1:0]  tx_baud;
    logic [2:0]         tx_bit;
    uart_byte_t         tx_shift;
    logic               tx_busy;
    logic               tx_baud_end;

    // receiver.
    logic [1:0]         rx_sync;
    logic               rx_line;
    uart_rx_state_t     rx_state;
    logic [BAUD_W-1:0]  rx_baud;
    logic [2:0]         rx_bit;
    uart_byte_t         rx_shift;
    uart_byte_t         rx_byte;
    logic               rx_sample;
    logic               rx_done;
    logic               rx_valid;
    logic               overrun;

    assign reg_ofs = i_req.adr[3:2];
    assign bus_hit = i_sel & i_req.cyc & i_req.stb & ~bus_ack;

    // writes to DATA while busy are dropped.
    assign tx_load = bus_hit & i_req.we & (reg_ofs == REG_DATA) & i_req.sel[0] & ~tx_busy;
    assign data_rd = bus_hit & ~i_req.we & (reg_ofs == REG_DATA);

    always_comb begin
        case (reg_ofs)
            REG_DATA:   reg_rdata = wb_data_t'(rx_byte);
            REG_STATUS: reg_rdata = wb_data_t'({overrun, rx_valid, tx_busy});
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            bus_ack   <= 1'b0;
            bus_rdata <= '0;
        end else begin
            bus_ack   <= bus_hit;
            bus_rdata <= (bus_hit && !i_req.we) ? reg_rdata : '0;
        end
    end

    assign o_rsp.dat = bus_rdata;
    assign o_rsp.ack = bus_ack;

    assign tx_busy     = (tx_state != TX_IDLE);
    assign tx_baud_end = (tx_baud == BIT_LAST);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tx_state <= TX_IDLE;
            tx_baud  <= '0;
            tx_bit   <= '0;
        end else begin
            tx_baud <= (tx_state == TX_IDLE || tx_baud_end) ? '0 : tx_baud + 1'b1;
            case (tx_state)
                TX_IDLE: begin
                    if (tx_load) begin
                        tx_state <= TX_START;
                    end
                end
                TX_START: begin
                    if (tx_baud_end) begin
                        tx_state <= TX_DATA;
                        tx_bit   <= '0;
                    end
                end
                TX_DATA: begin
                    if (tx_baud_end) begin
                        tx_bit <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            tx_state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (tx_baud_end) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // lsb first.
    always_ff @(posedge i_clk) begin
        if (tx_load) begin
            tx_shift <= i_req.dat[7:0];
        end else if (tx_state == TX_DATA && tx_baud_end) begin
            tx_shift <= {1'b0, tx_shift[7:1]};
        end
    end

    always_comb begin
        case (tx_state)
            TX_START: o_tx = 1'b0;
            TX_DATA:  o_tx = tx_shift[0];
            default:  o_tx = 1'b1;
        endcase
    end

    // line idles high.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    assign rx_line   = rx_sync[1];
    assign rx_sample = (rx_state == RX_DATA) && (rx_baud == BIT_LAST);
    assign rx_done   = (rx_state == RX_STOP) && (rx_baud == BIT_LAST) && rx_line;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_state <= RX_IDLE;
            rx_baud  <= '0;
            rx_bit   <= '0;
        end else begin
            case (rx_state)
                RX_IDLE: begin
                    rx_baud <= '0;
                    if (!rx_line) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    // start bit must still be low at mid-bit.
                    if (rx_baud == BIT_MID) begin
                        rx_baud  <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_line ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_baud <= rx_baud + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_baud == BIT_LAST) begin
                        rx_baud <= '0;
                        rx_bit  <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        rx_baud <= rx_baud + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (rx_baud == BIT_LAST) begin
                        rx_baud  <= '0;
                        rx_state <= RX_IDLE;
                    end else begin
                        rx_baud <= rx_baud + 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (rx_sample) begin
            rx_shift <= {rx_line, rx_shift[7:1]};
        end
        if (rx_done) begin
            rx_byte <= rx_shift;
        end
    end

    // a new byte over an unread one flags overrun.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            rx_valid <= rx_done | (rx_valid & ~data_rd);
            overrun  <= (overrun & ~data_rd) | (rx_done & rx_valid & ~data_rd);
        end
    end

endmodule

// File: testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one classic cycle with the request held until ack.
task automatic bus_cycle(input logic we, input wb_addr_t addr, input wb_data_t data,
                         input wb_sel_t sel, output wb_data_t rdata);
    wb_req_t next_req;
    int      waited;
    next_req     = '0;
    next_req.adr = addr;
    next_req.dat = data;
    next_req.sel = sel;
    next_req.we  = we;
    next_req.stb = 1'b1;
    next_req.cyc = 1'b1;
    waited       = 0;
    @(posedge clk);
    req <= next_req;
    @(negedge clk);
    while (!rsp.ack) begin
        waited++;
        if (waited >= ACK_WAIT_LIMIT) begin
            abort_run($sformatf("no ack from address 0x%08h after %0d cycles", addr, waited));
        end
        @(negedge clk);
    end
    rdata = rsp.dat;
    // stb low for a cycle before the next request.
    @(posedge clk);
    req <= '0;
endtask

task automatic bus_write(input wb_addr_t addr, input wb_data_t data, input wb_sel_t sel);
    wb_data_t ignored_dat;
    bus_cycle(1'b1, addr, data, sel, ignored_dat);
endtask

task automatic bus_read(input wb_addr_t addr, output wb_data_t rdata);
    bus_cycle(1'b0, addr, '0, 4'hf, rdata);
endtask

task automatic check_data(input string name, input wb_data_t exp_val, input wb_data_t act_val);
    if (act_val !== exp_val) begin
        abort_run($sformatf("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h",
                            $time, name, exp_val, act_val));
    end
endtask

task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        abort_run($sformatf("[ERROR] t=%0t %s expected %b actual %b",
                            $time, name, exp_val, act_val));
    end
endtask

`endif

// File: testbench/tb_soc_periph.sv
`timescale 1ns/1ps

module tb_soc_periph;

    import soc_bus_pkg::*;

    localparam int TCM_ADDR_WIDTH = 8;
    localparam int UART_COUNT     = 2;
    localparam int CLKS_PER_BIT   = 8;
    localparam int SEED           = 40272;
    localparam int ACK_WAIT_LIMIT = 4;
    localparam int ROW_CYCLES     = 12 * CLKS_PER_BIT + 8;

    localparam wb_addr_t CH0_DATA   = 32'h1000_0000;
    localparam wb_addr_t CH0_STATUS = 32'h1000_0004;
    localparam wb_addr_t CH1_DATA   = 32'h2000_0000;
    localparam wb_addr_t CH1_STATUS = 32'h2000_0004;
    localparam wb_addr_t UNMAPPED   = 32'h7000_0000;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_POLL
    } op_t;

    // for a poll row, data is the status mask.
    typedef struct packed {
        op_t        op;
        wb_addr_t   addr;
        wb_data_t   data;
        wb_sel_t    sel;
        wb_data_t   exp_val;
    } step_t;

    logic                   clk;
    logic                   rst;
    wb_req_t                req;
    wb_rsp_t                rsp;
    logic [UART_COUNT-1:0]  rx;
    logic [UART_COUNT-1:0]  tx;

    step_t  steps[$];
    int     cycle_count = 0;
    int     cycle_limit = 0;

    soc_periph_top #(
        .TCM_ADDR_WIDTH (TCM_ADDR_WIDTH),
        .UART_COUNT     (UART_COUNT),
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) DUT (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_req          (req),
        .o_rsp          (rsp),
        .i_rx           (rx),
        .o_tx           (tx)
    );

    // crossed loopback.
    assign rx = {tx[0], tx[1]};

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    `include "tb_checks.svh"

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    function automatic wb_data_t merge_lanes(wb_data_t old_word, wb_data_t new_word,
                                             wb_sel_t sel);
        wb_data_t result;
        result = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (sel[lane]) begin
                result[8*lane +: 8] = new_word[8*lane +: 8];
            end
        end
        return result;
    endfunction

    function automatic void add_step(op_t op, wb_addr_t addr, wb_data_t data, wb_sel_t sel,
                                     wb_data_t exp_val);
        steps.push_back('{op, addr, data, sel, exp_val});
    endfunction

    task automatic fill_table();
        wb_data_t   w0;
        wb_data_t   w1;
        wb_data_t   w2;
        wb_data_t   lane_a;
        wb_data_t   lane_b;
        wb_data_t   junk;
        uart_byte_t b_fwd;
        uart_byte_t b_drop;
        uart_byte_t b_back;
        uart_byte_t b_p;
        uart_byte_t b_q;
        uart_byte_t b_first;
        uart_byte_t b_second;
        w0       = $urandom();
        w1       = $urandom();
        w2       = $urandom();
        lane_a   = $urandom();
        lane_b   = $urandom();
        junk     = $urandom();
        b_fwd    = uart_byte_t'($urandom());
        b_drop   = b_fwd ^ 8'hff;
        b_back   = uart_byte_t'($urandom());
        b_p      = uart_byte_t'($urandom());
        b_q      = uart_byte_t'($urandom());
        b_first  = uart_byte_t'($urandom());
        b_second = b_first ^ 8'h5a;
        add_step(OP_READ, CH0_STATUS, '0, 4'hf, '0);
        add_step(OP_READ, CH1_STATUS, '0, 4'hf, '0);
        // byte masked memory.
        add_step(OP_WRITE, 32'h0000_0010, w0, 4'hf, '0);
        add_step(OP_WRITE, 32'h0000_0014, w1, 4'hf, '0);
        add_step(OP_WRITE, 32'h0000_03fc, w2, 4'hf, '0);
        add_step(OP_WRITE, 32'h0000_0010, lane_a, 4'b0001, '0);
        add_step(OP_WRITE, 32'h0000_0014, lane_b, 4'b1010, '0);
        add_step(OP_WRITE, 32'h0000_03fc, lane_a, 4'b1100, '0);
        add_step(OP_READ, 32'h0000_0010, '0, 4'hf, merge_lanes(w0, lane_a, 4'b0001));
        add_step(OP_READ, 32'h0000_0014, '0, 4'hf, merge_lanes(w1, lane_b, 4'b1010));
        add_step(OP_READ, 32'h0000_03fc, '0, 4'hf, merge_lanes(w2, lane_a, 4'b1100));
        // unmapped region.
        add_step(OP_READ, UNMAPPED, '0, 4'hf, '0);
        add_step(OP_WRITE, UNMAPPED + 32'h14, junk, 4'hf, '0);
        add_step(OP_READ, 32'h0000_0014, '0, 4'hf, merge_lanes(w1, lane_b, 4'b1010));
        // second write lands while busy and is lost.
        add_step(OP_WRITE, CH0_DATA, 32'(b_fwd), 4'b0001, '0);
        add_step(OP_READ, CH0_STATUS, '0, 4'hf, 32'h1);
        add_step(OP_WRITE, CH0_DATA, 32'(b_drop), 4'b0001, '0);
        add_step(OP_POLL, CH1_STATUS, 32'h2, 4'hf, 32'h2);
        add_step(OP_READ, CH1_DATA, '0, 4'hf, 32'(b_fwd));
        add_step(OP_READ, CH1_STATUS, '0, 4'hf, '0);
        add_step(OP_WRITE, CH1_DATA, 32'(b_back), 4'b0001, '0);
        add_step(OP_POLL, CH0_STATUS, 32'h2, 4'hf, 32'h2);
        add_step(OP_READ, CH0_DATA, '0, 4'hf, 32'(b_back));
        add_step(OP_READ, CH0_STATUS, '0, 4'hf, '0);
        // both directions at once.
        add_step(OP_POLL, CH1_STATUS, 32'h1, 4'hf, '0);
        add_step(OP_WRITE, CH0_DATA, 32'(b_p), 4'b0001, '0);
        add_step(OP_WRITE, CH1_DATA, 32'(b_q), 4'b0001, '0);
        add_step(OP_POLL, CH1_STATUS, 32'h2, 4'hf, 32'h2);
        add_step(OP_READ, CH1_DATA, '0, 4'hf, 32'(b_p));
        add_step(OP_POLL, CH0_STATUS, 32'h2, 4'hf, 32'h2);
        add_step(OP_READ, CH0_DATA, '0, 4'hf, 32'(b_q));
        // overrun with channel 1 left unread between bytes.
        add_step(OP_POLL, CH0_STATUS, 32'h1, 4'hf, '0);
        add_step(OP_WRITE, CH0_DATA, 32'(b_first), 4'b0001, '0);
        add_step(OP_POLL, CH0_STATUS, 32'h1, 4'hf, '0);
        add_step(OP_WRITE, CH0_DATA, 32'(b_second), 4'b0001, '0);
        add_step(OP_POLL, CH1_STATUS, 32'h4, 4'hf, 32'h4);
        add_step(OP_READ, CH1_STATUS, '0, 4'hf, 32'h6);
        add_step(OP_READ, CH1_DATA, '0, 4'hf, 32'(b_second));
        add_step(OP_READ, CH1_STATUS, '0, 4'hf, '0);
    endtask

    task automatic apply_step(input step_t s);
        wb_data_t rdata;
        case (s.op)
            OP_WRITE: bus_write(s.addr, s.data, s.sel);
            OP_READ: begin
                bus_read(s.addr, rdata);
                check_data($sformatf("o_rsp.dat @0x%08h", s.addr), s.exp_val, rdata);
            end
            default: begin
                bus_read(s.addr, rdata);
                while ((rdata & s.data) != s.exp_val) begin
                    bus_read(s.addr, rdata);
                end
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        void'($urandom(SEED));
        fill_table();
        cycle_limit = steps.size() * ROW_CYCLES;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("o_tx[0]", 1'b1, tx[0]);
        check_bit("o_tx[1]", 1'b1, tx[1]);
        check_bit("o_rsp.ack", 1'b0, rsp.ack);
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+testbench
hdl/soc_bus_pkg.sv
hdl/bus_decoder.sv
hdl/tcm.sv
hdl/uart_channel.sv
hdl/bus_read_mux.sv
hdl/soc_periph_top.sv
testbench/tb_soc_periph.sv
